//--- store_sink.f
store_sink_pkg.sv
sink_addrgen.sv
sink_addr_fifo.sv
sink_store_align.sv
sink_streamer_ctrl.sv
store_sink.sv
tb_clk_gen.sv
tb_store_sink.sv

//--- Bender.yml
package:
  name: store_sink

sources:
  - store_sink_pkg.sv
  - sink_addrgen.sv
  - sink_addr_fifo.sv
  - sink_store_align.sv
  - sink_streamer_ctrl.sv
  - store_sink.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_store_sink.sv

//--- tb_store_sink.sv
/*
 * Store streamer testbench
 * Directed runs against a randomly granting memory model and a stream
 * driver with valid gaps, every store checked against the lane rules
 */

`timescale 1ns/100ps
`default_nettype none

module tb_store_sink;

  localparam int unsigned DATA_WIDTH  = 32;
  localparam int unsigned STORE_WIDTH = DATA_WIDTH + 32;

  // Expected run lengths in cycles, about four cycles per store plus setup
  localparam int unsigned RUN_CYCLES  = 4 * (8 + 8 + 24 + 12 + 28) + 16 * 6;
  localparam int unsigned WATCHDOG_NS = 20 * RUN_CYCLES * 8;

  typedef struct packed {
    logic [DATA_WIDTH-1:0]   data;
    logic [DATA_WIDTH/8-1:0] strb;
  } beat_t;

  typedef struct packed {
    store_sink_pkg::addr_t    addr;
    logic [STORE_WIDTH/8-1:0] be;
    logic [STORE_WIDTH-1:0]   data;
  } store_t;

  logic clk;
  logic rst_n;
  logic clear;
  logic enable;
  store_sink_pkg::sink_ctrl_t  ctrl;
  store_sink_pkg::sink_flags_t flags;
  logic [DATA_WIDTH-1:0]    stream_data;
  logic [DATA_WIDTH/8-1:0]  stream_strb;
  logic                     stream_valid;
  logic                     stream_ready;
  logic                     mem_req;
  logic                     mem_gnt;
  store_sink_pkg::addr_t    mem_addr;
  logic [STORE_WIDTH/8-1:0] mem_be;
  logic [STORE_WIDTH-1:0]   mem_data;

  // Beats still to be offered and stores still expected, in order
  beat_t       beat_q [$];
  store_t      exp_q [$];
  int unsigned valid_pct;
  int unsigned gnt_pct;
  int unsigned stores_seen;
  logic        prev_stall;
  store_t      prev_store;

  tb_clk_gen #(
    .PERIOD_NS    ( 8 ),
    .RESET_CYCLES ( 3 )
  ) i_clk_gen (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  store_sink #(
    .DATA_WIDTH ( DATA_WIDTH ),
    .MISALIGNED ( 1 ),
    .FIFO_DEPTH ( 2 )
  ) dut_i (
    .clk_i          ( clk          ),
    .rst_ni         ( rst_n        ),
    .clear_i        ( clear        ),
    .enable_i       ( enable       ),
    .ctrl_i         ( ctrl         ),
    .flags_o        ( flags        ),
    .stream_data_i  ( stream_data  ),
    .stream_strb_i  ( stream_strb  ),
    .stream_valid_i ( stream_valid ),
    .stream_ready_o ( stream_ready ),
    .mem_req_o      ( mem_req      ),
    .mem_gnt_i      ( mem_gnt      ),
    .mem_addr_o     ( mem_addr     ),
    .mem_be_o       ( mem_be       ),
    .mem_data_o     ( mem_data     )
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // Byte k of the beat lands in lane k plus the low address bits
  function automatic store_t expect_store(input store_sink_pkg::addr_t a, input beat_t b);
    store_t      s;
    int unsigned off;
    s      = '0;
    off    = a[1:0];
    s.addr = {a[31:2], 2'b00};
    for (int k = 0; k < DATA_WIDTH / 8; k++) begin
      s.data[8*(k+off) +: 8] = b.data[8*k +: 8];
      s.be[k+off]            = b.strb[k];
    end
    return s;
  endfunction

  function automatic store_sink_pkg::addrgen_ctrl_t make_cfg(
    input store_sink_pkg::addr_t base, input store_sink_pkg::addr_t stride,
    input store_sink_pkg::len_t len);
    store_sink_pkg::addrgen_ctrl_t cfg;
    cfg.base    = base;
    cfg.stride  = stride;
    cfg.tot_len = len;
    return cfg;
  endfunction

  // Memory model, grants at random and compares each completed store
  always @(posedge clk) begin
    store_t got;
    store_t want;
    got = {mem_addr, mem_be, mem_data};
    if (!rst_n) begin
      mem_gnt    <= 1'b0;
      prev_stall = 1'b0;
    end else begin
      if (mem_req) begin
        // A stalled request must come back unchanged
        if (prev_stall) begin
          check_val("mem_addr_o", got.addr, prev_store.addr);
          check_val("mem_be_o", got.be, prev_store.be);
          check_val("mem_data_o", got.data, prev_store.data);
        end
        if (mem_gnt) begin
          if (exp_q.size() == 0) begin
            abort_run("A store was granted while no beat was outstanding");
          end else begin
            want = exp_q.pop_front();
            check_val("mem_addr_o", got.addr, want.addr);
            check_val("mem_be_o", got.be, want.be);
            check_val("mem_data_o", got.data, want.data);
            stores_seen++;
          end
        end
      end else if (prev_stall) begin
        abort_run("The memory request dropped while it waited for a grant");
      end else begin
        // Idle port fields are all zero
        check_val("mem_addr_o", got.addr, '0);
        check_val("mem_be_o", got.be, '0);
        check_val("mem_data_o", got.data, '0);
      end
      // A clear may legally drop a stalled request
      prev_stall = mem_req & ~mem_gnt & ~clear;
      prev_store = got;
      mem_gnt <= (($urandom % 100) < gnt_pct);
    end
  end

  // Stream driver, holds a beat until it is taken and inserts random gaps
  always @(posedge clk) begin
    logic accepted;
    if (rst_n) begin
      accepted = stream_valid & stream_ready;
      if (accepted && beat_q.size() != 0) begin
        void'(beat_q.pop_front());
      end
      if (beat_q.size() == 0) begin
        stream_valid <= 1'b0;
      end else if ((stream_valid && !accepted) || (($urandom % 100) < valid_pct)) begin
        stream_valid <= 1'b1;
        stream_data  <= beat_q[0].data;
        stream_strb  <= beat_q[0].strb;
      end else begin
        stream_valid <= 1'b0;
      end
    end
  end

  // Queues the beats of one run and the stores they must produce
  task automatic load_run(input store_sink_pkg::addrgen_ctrl_t cfg, input int unsigned v_pct,
                          input int unsigned g_pct, input bit rand_strb);
    beat_t                 b;
    store_sink_pkg::addr_t a;
    @(negedge clk);
    valid_pct = v_pct;
    gnt_pct   = g_pct;
    for (int i = 0; i < cfg.tot_len; i++) begin
      b.data = $urandom;
      b.strb = rand_strb ? 4'(($urandom % 15) + 1) : 4'hF;
      a      = cfg.base + store_sink_pkg::addr_t'(i) * cfg.stride;
      beat_q.push_back(b);
      exp_q.push_back(expect_store(a, b));
    end
  endtask

  task automatic drive_start(input store_sink_pkg::addrgen_ctrl_t cfg);
    ctrl.addrgen   <= cfg;
    ctrl.req_start <= 1'b1;
    @(posedge clk);
    ctrl.req_start <= 1'b0;
  endtask

  task automatic start_run(input store_sink_pkg::addrgen_ctrl_t cfg);
    @(posedge clk);
    while (!flags.ready_start) begin
      @(posedge clk);
    end
    drive_start(cfg);
  endtask

  // Returns on the edge after the done pulse, once its length is checked
  // Stores of runs that are queued behind this one stay pending
  task automatic wait_done(input int unsigned len, input int unsigned left);
    int unsigned cycles;
    logic        gen_done;
    cycles   = 0;
    gen_done = 1'b0;
    @(posedge clk);
    while (!flags.done && cycles < 10 * (4 * len + 16)) begin
      gen_done = flags.addrgen_done;
      @(posedge clk);
      cycles++;
    end
    if (!flags.done) begin
      abort_run("The run did not signal done within its cycle limit");
    end else begin
      // The generator flag holds until the cycle in which done rises
      check_val("flags_o.addrgen_done", gen_done, 1'b1);
      check_val("pending stores", exp_q.size(), left);
      @(posedge clk);
      check_val("flags_o.done", flags.done, 1'b0);
      check_val("flags_o.ready_start", flags.ready_start, 1'b1);
      check_val("flags_o.addrgen_done", flags.addrgen_done, 1'b0);
    end
  endtask

  task automatic aligned_stores();
    store_sink_pkg::addrgen_ctrl_t cfg;
    cfg = make_cfg(32'h100, 32'h4, 16'd8);
    @(posedge clk);
    check_val("mem_req_o", mem_req, 1'b0);
    check_val("flags_o.done", flags.done, 1'b0);
    check_val("flags_o.ready_start", flags.ready_start, 1'b1);
    check_val("stream_ready_o", stream_ready, 1'b1);
    load_run(cfg, 100, 100, 1'b0);
    start_run(cfg);
    wait_done(8, 0);
  endtask

  // Byte offset three spills each word into the upper half of the store
  task automatic misaligned_stores();
    store_sink_pkg::addrgen_ctrl_t cfg;
    cfg = make_cfg(32'h203, 32'h4, 16'd8);
    load_run(cfg, 100, 70, 1'b0);
    start_run(cfg);
    wait_done(8, 0);
  endtask

  // Stride seven walks through every lane offset
  task automatic backpressure_stores();
    store_sink_pkg::addrgen_ctrl_t cfg;
    cfg = make_cfg(32'h1001, 32'h7, 16'd24);
    load_run(cfg, 60, 40, 1'b1);
    start_run(cfg);
    wait_done(24, 0);
  endtask

  // Beats of the second run wait on the stream while the first one ends
  task automatic back_to_back_runs();
    store_sink_pkg::addrgen_ctrl_t cfg_a;
    store_sink_pkg::addrgen_ctrl_t cfg_b;
    cfg_a = make_cfg(32'h400, 32'h4, 16'd6);
    cfg_b = make_cfg(32'h801, 32'hC, 16'd6);
    load_run(cfg_a, 80, 60, 1'b0);
    load_run(cfg_b, 80, 60, 1'b0);
    start_run(cfg_a);
    wait_done(6, 6);
    drive_start(cfg_b);
    wait_done(6, 0);
  endtask

  task automatic clear_mid_run();
    store_sink_pkg::addrgen_ctrl_t cfg;
    int unsigned                   first;
    int unsigned                   cycles;
    cfg = make_cfg(32'h300, 32'h4, 16'd20);
    load_run(cfg, 100, 50, 1'b0);
    first  = stores_seen;
    cycles = 0;
    start_run(cfg);
    while (stores_seen < first + 5 && cycles < 200) begin
      @(negedge clk);
      cycles++;
    end
    if (stores_seen < first + 5) begin
      abort_run("The run stopped issuing stores before the clear");
    end else begin
      @(posedge clk);
      clear <= 1'b1;
      @(posedge clk);
      clear <= 1'b0;
      @(posedge clk);
      check_val("mem_req_o", mem_req, 1'b0);
      check_val("flags_o.ready_start", flags.ready_start, 1'b1);
      // Drop the remains of the aborted run
      @(negedge clk);
      beat_q.delete();
      exp_q.delete();
      repeat (2) @(posedge clk);
      cfg = make_cfg(32'h100, 32'h4, 16'd8);
      load_run(cfg, 100, 100, 1'b0);
      start_run(cfg);
      wait_done(8, 0);
    end
  endtask

  initial begin
    void'($urandom(32'h82fa));
    clear        = 1'b0;
    enable       = 1'b1;
    ctrl         = '0;
    stream_data  = '0;
    stream_strb  = '0;
    stream_valid = 1'b0;
    mem_gnt      = 1'b0;
    valid_pct    = 100;
    gnt_pct      = 100;
    stores_seen  = 0;
    prev_stall   = 1'b0;
    prev_store   = '0;
    @(posedge rst_n);
    aligned_stores();
    misaligned_stores();
    backpressure_stores();
    back_to_back_runs();
    clear_mid_run();
    @(posedge clk);
    $display("No errors");
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    abort_run("Timeout, the tests did not finish within the watchdog limit");
  end

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
/*
 * Testbench clock and reset
 * Free-running clock and an active-low reset held for a few cycles
 */

`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS    = 8,
  parameter int unsigned RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_no
);

  always #(PERIOD_NS / 2) clk_o = ~clk_o;

  // Reset is released on a rising edge once the cycles have passed
  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

`default_nettype wire

//--- store_sink.sv
/*
 * Store streamer top level
 * Small DMA engine that turns a valid/ready data stream into word stores
 * on a request/grant memory port, following a base, stride, length pattern
 */

`timescale 1ns/100ps
`default_nettype none

module store_sink #(
  parameter int unsigned DATA_WIDTH = 32,
  parameter int unsigned MISALIGNED = 1,
  parameter int unsigned FIFO_DEPTH = 2,
  localparam int unsigned STORE_WIDTH = (MISALIGNED == 1) ? DATA_WIDTH + 32 : DATA_WIDTH
) (
  input  wire                              clk_i,
  input  wire                              rst_ni,
  input  wire                              clear_i,
  input  wire                              enable_i,
  input  wire store_sink_pkg::sink_ctrl_t  ctrl_i,
  output store_sink_pkg::sink_flags_t      flags_o,
  input  wire [DATA_WIDTH-1:0]             stream_data_i,
  input  wire [DATA_WIDTH/8-1:0]           stream_strb_i,
  input  wire                              stream_valid_i,
  output logic                             stream_ready_o,
  output logic                             mem_req_o,
  input  wire                              mem_gnt_i,
  output store_sink_pkg::addr_t            mem_addr_o,
  output logic [STORE_WIDTH/8-1:0]         mem_be_o,
  output logic [STORE_WIDTH-1:0]           mem_data_o
);

  // Generator to FIFO
  store_sink_pkg::addr_t gen_addr;
  logic                  gen_valid;
  logic                  fifo_push_ready;

  // FIFO head to controller and aligner
  store_sink_pkg::addr_t head_addr;
  logic                  head_valid;
  logic                  head_pop;

  // Aligned store word
  logic [STORE_WIDTH-1:0]   aligned_data;
  logic [STORE_WIDTH/8-1:0] aligned_be;

  // Controller to generator
  logic addrgen_start;
  logic addrgen_clear;

  // Input side, address generation
  sink_addrgen i_addrgen (
    .clk_i        ( clk_i                ),
    .rst_ni       ( rst_ni               ),
    .clear_i      ( addrgen_clear        ),
    .enable_i     ( enable_i             ),
    .start_i      ( addrgen_start        ),
    .ctrl_i       ( ctrl_i.addrgen       ),
    .addr_ready_i ( fifo_push_ready      ),
    .addr_o       ( gen_addr             ),
    .addr_valid_o ( gen_valid            ),
    .done_o       ( flags_o.addrgen_done )
  );

  sink_addr_fifo #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) i_addr_fifo (
    .clk_i        ( clk_i           ),
    .rst_ni       ( rst_ni          ),
    .clear_i      ( clear_i         ),
    .push_data_i  ( gen_addr        ),
    .push_valid_i ( gen_valid       ),
    .push_ready_o ( fifo_push_ready ),
    .pop_data_o   ( head_addr       ),
    .pop_valid_o  ( head_valid      ),
    .pop_ready_i  ( head_pop        )
  );

  // Processing, lane alignment from the low bits of the FIFO head
  sink_store_align #(
    .DATA_WIDTH ( DATA_WIDTH ),
    .MISALIGNED ( MISALIGNED )
  ) i_store_align (
    .offset_i ( head_addr[1:0] ),
    .data_i   ( stream_data_i  ),
    .strb_i   ( stream_strb_i  ),
    .data_o   ( aligned_data   ),
    .be_o     ( aligned_be     )
  );

  // Output side, store port and run sequencing
  sink_streamer_ctrl #(
    .DATA_WIDTH ( DATA_WIDTH ),
    .MISALIGNED ( MISALIGNED )
  ) i_streamer_ctrl (
    .clk_i           ( clk_i                  ),
    .rst_ni          ( rst_ni                 ),
    .clear_i         ( clear_i                ),
    .enable_i        ( enable_i               ),
    .req_start_i     ( ctrl_i.req_start       ),
    .tot_len_i       ( ctrl_i.addrgen.tot_len ),
    .addrgen_done_i  ( flags_o.addrgen_done   ),
    .stream_valid_i  ( stream_valid_i         ),
    .stream_ready_o  ( stream_ready_o         ),
    .addr_valid_i    ( head_valid             ),
    .addr_i          ( head_addr              ),
    .addr_pop_o      ( head_pop               ),
    .data_i          ( aligned_data           ),
    .be_i            ( aligned_be             ),
    .mem_req_o       ( mem_req_o              ),
    .mem_gnt_i       ( mem_gnt_i              ),
    .mem_addr_o      ( mem_addr_o             ),
    .mem_be_o        ( mem_be_o               ),
    .mem_data_o      ( mem_data_o             ),
    .ready_start_o   ( flags_o.ready_start    ),
    .done_o          ( flags_o.done           ),
    .addrgen_start_o ( addrgen_start          ),
    .addrgen_clear_o ( addrgen_clear          )
  );

endmodule

`default_nettype wire

//--- sink_streamer_ctrl.sv
/*
 * Streamer controller
 * Joins the address FIFO head and aligned stream data into memory stores,
 * counts granted stores and sequences idle, working and done
 */

`timescale 1ns/100ps
`default_nettype none

module sink_streamer_ctrl #(
  parameter int unsigned DATA_WIDTH = 32,
  parameter int unsigned MISALIGNED = 1,
  localparam int unsigned STORE_WIDTH = (MISALIGNED == 1) ? DATA_WIDTH + 32 : DATA_WIDTH
) (
  input  wire                        clk_i,
  input  wire                        rst_ni,
  input  wire                        clear_i,
  input  wire                        enable_i,
  input  wire                        req_start_i,
  input  wire store_sink_pkg::len_t  tot_len_i,
  input  wire                        addrgen_done_i,
  input  wire                        stream_valid_i,
  output logic                       stream_ready_o,
  input  wire                        addr_valid_i,
  input  wire store_sink_pkg::addr_t addr_i,
  output logic                       addr_pop_o,
  input  wire [STORE_WIDTH-1:0]      data_i,
  input  wire [STORE_WIDTH/8-1:0]    be_i,
  output logic                       mem_req_o,
  input  wire                        mem_gnt_i,
  output store_sink_pkg::addr_t      mem_addr_o,
  output logic [STORE_WIDTH/8-1:0]   mem_be_o,
  output logic [STORE_WIDTH-1:0]     mem_data_o,
  output logic                       ready_start_o,
  output logic                       done_o,
  output logic                       addrgen_start_o,
  output logic                       addrgen_clear_o
);

  store_sink_pkg::streamer_state_e state_q;
  store_sink_pkg::streamer_state_e state_d;

  // Stores granted in the current run
  store_sink_pkg::len_t store_cnt_q;

  logic active;
  logic store_hs;
  logic run_end;

  assign active = (state_q != store_sink_pkg::STREAMER_IDLE);

  // A store needs both a data beat and an address from the FIFO
  assign mem_req_o = active & stream_valid_i & addr_valid_i;

  // Fields are held at zero whenever no request is out
  assign mem_addr_o = mem_req_o ? {addr_i[store_sink_pkg::ADDR_WIDTH-1:2], 2'b00} : '0;
  assign mem_be_o   = mem_req_o ? be_i : '0;
  assign mem_data_o = mem_req_o ? data_i : '0;

  assign store_hs = mem_req_o & mem_gnt_i;

  // Ready is high while no beat is offered, so an idle stream never stalls
  // Otherwise the beat and the FIFO head leave together on a grant
  assign stream_ready_o = ~stream_valid_i | store_hs;
  assign addr_pop_o     = store_hs;

  // Next-state logic
  always_comb begin
    state_d         = state_q;
    ready_start_o   = 1'b0;
    addrgen_start_o = 1'b0;
    run_end         = 1'b0;
    unique case (state_q)
      store_sink_pkg::STREAMER_IDLE: begin
        ready_start_o = 1'b1;
        if (req_start_i) begin
          state_d         = store_sink_pkg::STREAMER_WORKING;
          addrgen_start_o = 1'b1;
        end
      end
      store_sink_pkg::STREAMER_WORKING: begin
        if (addrgen_done_i) begin
          state_d = store_sink_pkg::STREAMER_DONE;
        end
      end
      store_sink_pkg::STREAMER_DONE: begin
        // Wait here until the last issued address has been stored
        if (store_cnt_q == tot_len_i) begin
          state_d = store_sink_pkg::STREAMER_IDLE;
          run_end = 1'b1;
        end
      end
      default: begin
        state_d = store_sink_pkg::STREAMER_IDLE;
      end
    endcase
  end

  // The generator is reset on an external clear and on the end of a run
  assign addrgen_clear_o = clear_i | (run_end & enable_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= store_sink_pkg::STREAMER_IDLE;
    end else if (clear_i) begin
      state_q <= store_sink_pkg::STREAMER_IDLE;
    end else if (enable_i) begin
      state_q <= state_d;
    end
  end

  // Granted store counter
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      store_cnt_q <= '0;
    end else if (clear_i) begin
      store_cnt_q <= '0;
    end else if (enable_i) begin
      if (run_end) begin
        store_cnt_q <= '0;
      end else if (store_hs) begin
        store_cnt_q <= store_cnt_q + 1'b1;
      end
    end
  end

  // Done is a registered one-cycle pulse, it coincides with the first idle cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_o <= 1'b0;
    end else if (clear_i) begin
      done_o <= 1'b0;
    end else if (enable_i) begin
      done_o <= run_end;
    end
  end

endmodule

`default_nettype wire

//--- sink_store_align.sv
/*
 * Store aligner
 * Moves a stream word and its byte strobes to the byte lane given by the
 * low address bits inside a store word one 32-bit word wider
 */

`timescale 1ns/100ps
`default_nettype none

module sink_store_align #(
  parameter int unsigned DATA_WIDTH = 32,
  parameter int unsigned MISALIGNED = 1,
  localparam int unsigned STORE_WIDTH = (MISALIGNED == 1) ? DATA_WIDTH + 32 : DATA_WIDTH
) (
  input  wire [1:0]              offset_i,
  input  wire [DATA_WIDTH-1:0]   data_i,
  input  wire [DATA_WIDTH/8-1:0] strb_i,
  output logic [STORE_WIDTH-1:0]   data_o,
  output logic [STORE_WIDTH/8-1:0] be_o
);

  if (MISALIGNED == 1) begin : gen_shift
    logic [STORE_WIDTH-1:0]   data_ext;
    logic [STORE_WIDTH/8-1:0] strb_ext;

    // Zero-extend into the wide word so that vacated lanes stay disabled
    assign data_ext = STORE_WIDTH'(data_i);
    assign strb_ext = (STORE_WIDTH/8)'(strb_i);

    // One lane of shift per byte of offset, the top word absorbs the spill
    assign data_o = data_ext << {offset_i, 3'b000};
    assign be_o   = strb_ext << offset_i;
  end else begin : gen_pass
    // Word-aligned traffic only, the low address bits carry no lane
    assign data_o = data_i;
    assign be_o   = strb_i;
  end

endmodule

`default_nettype wire

//--- sink_addr_fifo.sv
/*
 * Address FIFO
 * Register-array FIFO between the address generator and store issue,
 * with simultaneous push and pop and a synchronous clear
 */

`timescale 1ns/100ps
`default_nettype none

module sink_addr_fifo #(
  parameter int unsigned FIFO_DEPTH = 2
) (
  input  wire                        clk_i,
  input  wire                        rst_ni,
  input  wire                        clear_i,
  input  wire store_sink_pkg::addr_t push_data_i,
  input  wire                        push_valid_i,
  output logic                       push_ready_o,
  output store_sink_pkg::addr_t      pop_data_o,
  output logic                       pop_valid_o,
  input  wire                        pop_ready_i
);

  // A depth of one still needs a one-bit pointer
  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  store_sink_pkg::addr_t mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0]      wr_ptr_q;
  logic [PTR_W-1:0]      rd_ptr_q;
  logic [CNT_W-1:0]      count_q;
  logic                  push;
  logic                  pop;

  // Pointers wrap at the depth, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Full blocks a push even when a pop happens in the same cycle
  assign push_ready_o = (count_q != CNT_W'(FIFO_DEPTH));
  assign pop_valid_o  = (count_q != '0);
  assign pop_data_o   = mem_q[rd_ptr_q];

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_ready_i & pop_valid_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      // Occupancy only moves when exactly one side transfers
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage array
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

`default_nettype wire

//--- sink_addrgen.sv
/*
 * Store address generator
 * Emits base + i*stride for i = 0 .. tot_len-1 as a valid/ready stream
 * and flags the end of the sequence once the last address is taken
 */

`timescale 1ns/100ps
`default_nettype none

module sink_addrgen (
  input  wire                           clk_i,
  input  wire                           rst_ni,
  input  wire                           clear_i,
  input  wire                           enable_i,
  input  wire                           start_i,
  input  wire store_sink_pkg::addrgen_ctrl_t ctrl_i,
  input  wire                           addr_ready_i,
  output store_sink_pkg::addr_t         addr_o,
  output logic                          addr_valid_o,
  output logic                          done_o
);

  // Current address and the stride it advances by
  store_sink_pkg::addr_t cur_addr_q;
  store_sink_pkg::addr_t stride_q;

  // Addresses still to be issued in this run
  store_sink_pkg::len_t  remain_q;

  logic                  busy_q;
  logic                  done_q;
  logic                  addr_hs;

  // An address leaves only while enabled, so the FIFO never takes a copy
  // of an address that the generator did not advance past
  assign addr_valid_o = busy_q & enable_i;
  assign addr_o       = cur_addr_q;
  assign done_o       = done_q;

  assign addr_hs = addr_valid_o & addr_ready_i;

  // Sequencing state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q   <= 1'b0;
      done_q   <= 1'b0;
      remain_q <= '0;
    end else if (clear_i) begin
      busy_q   <= 1'b0;
      done_q   <= 1'b0;
      remain_q <= '0;
    end else if (enable_i) begin
      if (start_i) begin
        // A zero-length run is finished as soon as it starts
        busy_q   <= (ctrl_i.tot_len != '0);
        done_q   <= (ctrl_i.tot_len == '0);
        remain_q <= ctrl_i.tot_len;
      end else if (addr_hs) begin
        remain_q <= remain_q - 1'b1;
        // Last address of the run has just been taken
        if (remain_q == store_sink_pkg::len_t'(1)) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  // Address datapath
  // The configuration is sampled on the same edge that starts the run
  always_ff @(posedge clk_i) begin
    if (enable_i) begin
      if (start_i) begin
        cur_addr_q <= ctrl_i.base;
        stride_q   <= ctrl_i.stride;
      end else if (addr_hs) begin
        cur_addr_q <= cur_addr_q + stride_q;
      end
    end
  end

endmodule

`default_nettype wire

//--- store_sink_pkg.sv
/*
 * Store streamer package
 * Width constants, vector types, control and flag structs and the
 * controller state encoding shared by the store streamer blocks
 */

`default_nettype none

package store_sink_pkg;

  // Memory byte address width
  parameter int unsigned ADDR_WIDTH = 32;

  // Width of the transfer counter, runs overflow at 2^TRANS_CNT transfers
  parameter int unsigned TRANS_CNT = 16;

  // Byte address on the memory port
  typedef logic [ADDR_WIDTH-1:0] addr_t;

  // Transfer count
  typedef logic [TRANS_CNT-1:0] len_t;

  // One-dimensional store pattern
  // Base and stride are in bytes, tot_len is the number of stores in the run
  typedef struct packed {
    addr_t base;
    addr_t stride;
    len_t  tot_len;
  } addrgen_ctrl_t;

  // Top-level control input
  // The req_start bit is a strobe, only taken while ready_start is high
  typedef struct packed {
    logic          req_start;
    addrgen_ctrl_t addrgen;
  } sink_ctrl_t;

  // Top-level flag output
  typedef struct packed {
    logic ready_start;
    logic done;
    logic addrgen_done;
  } sink_flags_t;

  // Controller sequence
  // Idle waits for a start, working issues stores until the generator is
  // finished, done drains the remaining stores before returning to idle
  typedef enum logic [1:0] {
    STREAMER_IDLE    = 2'b00,
    STREAMER_WORKING = 2'b01,
    STREAMER_DONE    = 2'b10
  } streamer_state_e;

endpackage

`default_nettype wire
